//--- hw/frame_parity_pkg.sv
// frame parity types shared by the parity stage, the beat FIFO and the frame packer
`default_nettype none

package frame_parity_pkg;

    // widths here are tied to the 8-bit mask, so they stay fixed
    typedef logic [7:0] data_byte_t;     // one stream byte
    typedef logic [3:0] frame_count_t;   // bytes seen in a frame, saturates at 15
    typedef logic [7:0] parity_mask_t;   // bit i = parity of byte i

    // one beat per input byte, the byte itself is dropped after the parity stage
    typedef struct packed {
        logic parity;   // 1 for an even number of ones
        logic last;     // final byte of the frame
    } parity_beat_t;

    // result of one frame as seen on the output link
    typedef struct packed {
        parity_mask_t mask;
        frame_count_t count;
        logic         overflow;  // frame longer than the mask
    } frame_summary_t;

endpackage

`default_nettype wire

//--- hw/byte_parity_stage.sv
// byte parity stage: registers the XNOR parity and last flag of every accepted byte
`timescale 1ns/1ps
`default_nettype none

module byte_parity_stage (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire frame_parity_pkg::data_byte_t data_in,
    input  wire                           last_in,
    input  wire                           valid_in,
    output logic                          ready_out,
    output frame_parity_pkg::parity_beat_t beat_out,
    output logic                          valid_out,
    input  wire                           ready_in
);
    import frame_parity_pkg::*;

    logic [3:0]   xor_pair;     // first level of the tree
    logic [1:0]   xor_quad;     // second level
    logic         parity_xnor;
    logic         take_byte;
    parity_beat_t beat_q;
    logic         valid_q;

    // balanced XOR tree over the byte
    assign xor_pair[0] = data_in[0] ^ data_in[1];
    assign xor_pair[1] = data_in[2] ^ data_in[3];
    assign xor_pair[2] = data_in[4] ^ data_in[5];
    assign xor_pair[3] = data_in[6] ^ data_in[7];

    assign xor_quad[0] = xor_pair[0] ^ xor_pair[1];
    assign xor_quad[1] = xor_pair[2] ^ xor_pair[3];

    assign parity_xnor = ~(xor_quad[0] ^ xor_quad[1]);  // even ones -> 1

    // empty, or the held beat leaves this cycle
    assign ready_out = !valid_q || ready_in;
    assign take_byte = valid_in && ready_out;

    assign beat_out  = beat_q;
    assign valid_out = valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (take_byte) begin
            valid_q <= 1'b1;
        end else if (ready_in) begin
            valid_q <= 1'b0;  // held beat taken, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (take_byte) begin
            beat_q.parity <= parity_xnor;
            beat_q.last   <= last_in;
        end
    end

endmodule

`default_nettype wire

//--- hw/parity_beat_fifo.sv
// parity beat FIFO: circular buffer with show-ahead read and valid-ready on both ports
`timescale 1ns/1ps
`default_nettype none

module parity_beat_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire frame_parity_pkg::parity_beat_t wr_beat,
    input  wire                             wr_valid,
    output logic                            wr_ready,
    output frame_parity_pkg::parity_beat_t  rd_beat,
    output logic                            rd_valid,
    input  wire                             rd_ready
);
    import frame_parity_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(FIFO_DEPTH);

    parity_beat_t     mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;   // wraps on its own, depth is a power of two
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;    // occupancy, 0 .. FIFO_DEPTH
    logic             wr_fire;
    logic             rd_fire;

    assign wr_ready = (count_q != FULL_COUNT);
    assign rd_valid = (count_q != '0);

    assign wr_fire = wr_valid && wr_ready;
    assign rd_fire = rd_valid && rd_ready;

    // head entry always on the output
    assign rd_beat = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr_q] <= wr_beat;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end

            // simultaneous read and write leaves the count alone
            case ({wr_fire, rd_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/frame_parity_packer.sv
// frame packer: collects the parity beats of a frame into a mask, count and overflow summary
`timescale 1ns/1ps
`default_nettype none

module frame_parity_packer #(
    parameter int MAX_FRAME_BYTES = 8
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire frame_parity_pkg::parity_beat_t beat_in,
    input  wire                             beat_valid,
    output logic                            beat_ready,
    output frame_parity_pkg::frame_summary_t summary,
    output logic                            summary_valid,
    input  wire                             summary_ready
);
    import frame_parity_pkg::*;

    typedef enum logic {
        COLLECT,
        HOLD
    } pack_state_t;

    localparam frame_count_t MASK_LIMIT = frame_count_t'(MAX_FRAME_BYTES);
    localparam frame_count_t COUNT_MAX  = '1;

    pack_state_t    state_q;
    parity_mask_t   mask_q;       // frame being assembled
    frame_count_t   count_q;
    logic           overflow_q;
    frame_summary_t summary_q;    // finished frame waiting for the consumer

    parity_mask_t   mask_next;
    frame_count_t   count_next;
    logic           overflow_next;
    logic           beat_fire;

    assign beat_ready    = (state_q == COLLECT);
    assign beat_fire     = beat_valid && beat_ready;
    assign summary       = summary_q;
    assign summary_valid = (state_q == HOLD);

    // frame state with the incoming beat folded in
    always_comb begin
        mask_next     = mask_q;
        overflow_next = overflow_q;
        if (count_q < MASK_LIMIT) begin
            mask_next[count_q[2:0]] = beat_in.parity;  // count below 8 here
        end else begin
            overflow_next = 1'b1;  // no mask bit left
        end
        count_next = (count_q == COUNT_MAX) ? count_q : count_q + 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= COLLECT;
            mask_q     <= '0;
            count_q    <= '0;
            overflow_q <= 1'b0;
        end else begin
            case (state_q)
                COLLECT: begin
                    if (beat_fire && beat_in.last) begin
                        // start the next frame clean
                        mask_q     <= '0;
                        count_q    <= '0;
                        overflow_q <= 1'b0;
                        state_q    <= HOLD;
                    end else if (beat_fire) begin
                        mask_q     <= mask_next;
                        count_q    <= count_next;
                        overflow_q <= overflow_next;
                    end
                end
                HOLD: begin
                    if (summary_ready) begin
                        state_q <= COLLECT;  // summary taken
                    end
                end
                default: state_q <= COLLECT;
            endcase
        end
    end

    // capture on the last beat, held through back-pressure
    always_ff @(posedge clk) begin
        if (beat_fire && beat_in.last) begin
            summary_q.mask     <= mask_next;
            summary_q.count    <= count_next;
            summary_q.overflow <= overflow_next;
        end
    end

endmodule

`default_nettype wire

//--- hw/frame_parity_unit.sv
// frame parity unit top: parity stage, beat FIFO and frame packer chained on valid-ready links
`timescale 1ns/1ps
`default_nettype none

module frame_parity_unit #(
    parameter int FIFO_DEPTH      = 4,  // power of two
    parameter int MAX_FRAME_BYTES = 8   // 1 .. 8 mask bits in use
) (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire frame_parity_pkg::data_byte_t data_in,
    input  wire                              last_in,
    input  wire                              valid_in,
    output logic                             ready_out,
    output frame_parity_pkg::frame_summary_t summary,
    output logic                             summary_valid,
    input  wire                              summary_ready
);
    import frame_parity_pkg::*;

    // stage to FIFO
    parity_beat_t stage_beat;
    logic         stage_valid;
    logic         fifo_wr_ready;

    // FIFO to packer
    parity_beat_t fifo_beat;
    logic         fifo_valid;
    logic         packer_ready;

    byte_parity_stage u_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_in   (data_in),
        .last_in   (last_in),
        .valid_in  (valid_in),
        .ready_out (ready_out),
        .beat_out  (stage_beat),
        .valid_out (stage_valid),
        .ready_in  (fifo_wr_ready)
    );

    parity_beat_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_beat  (stage_beat),
        .wr_valid (stage_valid),
        .wr_ready (fifo_wr_ready),
        .rd_beat  (fifo_beat),
        .rd_valid (fifo_valid),
        .rd_ready (packer_ready)
    );

    // back-pressure from summary_ready ripples back to ready_out
    frame_parity_packer #(
        .MAX_FRAME_BYTES (MAX_FRAME_BYTES)
    ) u_packer (
        .clk           (clk),
        .rst_n         (rst_n),
        .beat_in       (fifo_beat),
        .beat_valid    (fifo_valid),
        .beat_ready    (packer_ready),
        .summary       (summary),
        .summary_valid (summary_valid),
        .summary_ready (summary_ready)
    );

endmodule

`default_nettype wire

//--- test/frame_parity_checker.sv
// frame parity checker that predicts each summary from the accepted bytes and compares it
`timescale 1ns/1ps
`default_nettype none

module frame_parity_checker #(
    parameter int N_FRAMES  = 10,
    parameter int MASK_BITS = 8
) (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire frame_parity_pkg::data_byte_t     data_in,
    input  wire                                  last_in,
    input  wire                                  valid_in,
    input  wire                                  ready_out,
    input  wire frame_parity_pkg::frame_summary_t summary,
    input  wire                                  summary_valid,
    input  wire                                  summary_ready,
    input  wire frame_parity_pkg::frame_summary_t expected_table [N_FRAMES],
    output int                                   pass_count,
    output int                                   fail_count,
    output int                                   frames_seen,
    output int                                   stall_cycles
);
    import frame_parity_pkg::*;

    frame_summary_t predicted_q [$];  // one entry per frame whose last byte went in
    parity_mask_t   acc_mask;
    int             acc_bytes;
    logic           reset_checked;

    // even number of ones gives 1
    function automatic logic even_ones(input data_byte_t value);
        int ones;
        int i;
        ones = 0;
        for (i = 0; i < 8; i++) begin
            ones = ones + (value[i] ? 1 : 0);
        end
        return (ones % 2) == 0;
    endfunction

    always @(posedge clk) begin
        frame_summary_t predicted;
        frame_summary_t table_entry;
        frame_summary_t finished;
        if (!rst_n) begin
            pass_count    = 0;
            fail_count    = 0;
            frames_seen   = 0;
            stall_cycles  = 0;
            acc_mask      = '0;
            acc_bytes     = 0;
            reset_checked = 1'b0;
            predicted_q.delete();
        end else begin
            // first edge out of reset with nothing driven yet
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (summary_valid !== 1'b0 || ready_out !== 1'b1) begin
                    $display("** Error at %0t: after reset summary_valid=%b ready_out=%b",
                             $time, summary_valid, ready_out);
                    fail_count = fail_count + 1;
                end else begin
                    $display("reset state: summary_valid low, ready_out high, ok");
                    pass_count = pass_count + 1;
                end
            end

            if (valid_in && !ready_out) begin
                stall_cycles = stall_cycles + 1;  // byte held off by back-pressure
            end

            // summary handshake
            if (summary_valid && summary_ready) begin
                table_entry = expected_table[frames_seen % N_FRAMES];
                if (predicted_q.size() == 0) begin
                    $display("frame %0d: a summary came out although no frame was sent",
                             frames_seen);
                    fail_count = fail_count + 1;
                end else begin
                    predicted = predicted_q.pop_front();
                    if (predicted !== table_entry) begin
                        $display("** Error at %0t: frame %0d table gives %h, bytes give %h",
                                 $time, frames_seen, table_entry, predicted);
                        fail_count = fail_count + 1;
                    end else if (summary !== predicted) begin
                        $display("** Error at %0t: frame %0d got %h/%0d/%b, expected %h/%0d/%b",
                                 $time, frames_seen, summary.mask, summary.count,
                                 summary.overflow, predicted.mask, predicted.count,
                                 predicted.overflow);
                        fail_count = fail_count + 1;
                    end else begin
                        $display("frame %0d: mask %h count %0d overflow %b, ok",
                                 frames_seen, summary.mask, summary.count, summary.overflow);
                        pass_count = pass_count + 1;
                    end
                end
                frames_seen = frames_seen + 1;
            end

            // input handshake
            if (valid_in && ready_out) begin
                if (acc_bytes < MASK_BITS) begin
                    acc_mask[acc_bytes[2:0]] = even_ones(data_in);
                end
                acc_bytes = acc_bytes + 1;
                if (last_in) begin
                    finished.mask     = acc_mask;
                    finished.count    = (acc_bytes > 15) ? 4'd15 : frame_count_t'(acc_bytes);
                    finished.overflow = (acc_bytes > MASK_BITS);
                    predicted_q.push_back(finished);
                    acc_mask  = '0;
                    acc_bytes = 0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- test/frame_parity_tb.sv
// frame parity testbench that runs the frame table back to back and then under back-pressure
`timescale 1ns/1ps
`default_nettype none

module frame_parity_tb;
    import frame_parity_pkg::*;

    localparam int FIFO_DEPTH      = 4;
    localparam int MAX_FRAME_BYTES = 8;
    localparam int N_FRAMES        = 10;
    localparam int N_BYTES         = 37;
    localparam int N_PASSES        = 2;
    localparam int WAIT_LIMIT      = 2000;  // cycles allowed per wait
    localparam int PATTERN_LEN     = 4096;
    localparam int SEED            = 88195;

    // frame lengths and bytes in order with the summary each frame must give
    localparam int FRAME_LEN [N_FRAMES] = '{1, 1, 1, 1, 2, 3, 5, 8, 11, 4};
    localparam data_byte_t TABLE_BYTES [N_BYTES] = '{
        8'h00, 8'hFF, 8'h01, 8'h80,
        8'h03, 8'h07,
        8'h10, 8'h11, 8'h3C,
        8'hA5, 8'h01, 8'hF0, 8'h7F, 8'h00,
        8'h00, 8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h06, 8'h07,
        8'hFF, 8'hFE, 8'h0F, 8'h1F, 8'h55, 8'hAA, 8'h81, 8'h80, 8'h12, 8'h34, 8'h56,
        8'hC3, 8'hE0, 8'h99, 8'h01
    };
    localparam frame_summary_t EXPECTED [N_FRAMES] = '{
        {8'h01, 4'd1, 1'b0},
        {8'h01, 4'd1, 1'b0},
        {8'h00, 4'd1, 1'b0},
        {8'h00, 4'd1, 1'b0},
        {8'h01, 4'd2, 1'b0},
        {8'h06, 4'd3, 1'b0},
        {8'h15, 4'd5, 1'b0},
        {8'h69, 4'd8, 1'b0},
        {8'h75, 4'd11, 1'b1},  // only the first 8 parities fit
        {8'h05, 4'd4, 1'b0}
    };

    logic           clk = 1'b0;
    logic           rst_n;
    data_byte_t     data_in;
    logic           last_in;
    logic           valid_in;
    logic           ready_out;
    frame_summary_t summary;
    logic           summary_valid;
    logic           summary_ready;

    int   pass_count;
    int   fail_count;
    int   frames_seen;
    int   stall_cycles;
    int   tb_errors;
    int   phase;        // 0 keeps summary_ready high and 1 takes it from the pattern
    logic timed_out;
    logic ready_pattern [PATTERN_LEN];

    always #20 clk = ~clk;

    frame_parity_unit #(
        .FIFO_DEPTH      (FIFO_DEPTH),
        .MAX_FRAME_BYTES (MAX_FRAME_BYTES)
    ) DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .data_in       (data_in),
        .last_in       (last_in),
        .valid_in      (valid_in),
        .ready_out     (ready_out),
        .summary       (summary),
        .summary_valid (summary_valid),
        .summary_ready (summary_ready)
    );

    frame_parity_checker #(
        .N_FRAMES  (N_FRAMES),
        .MASK_BITS (MAX_FRAME_BYTES)
    ) u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .data_in        (data_in),
        .last_in        (last_in),
        .valid_in       (valid_in),
        .ready_out      (ready_out),
        .summary        (summary),
        .summary_valid  (summary_valid),
        .summary_ready  (summary_ready),
        .expected_table (EXPECTED),
        .pass_count     (pass_count),
        .fail_count     (fail_count),
        .frames_seen    (frames_seen),
        .stall_cycles   (stall_cycles)
    );

    // long low runs so the FIFO and the stage fill up
    task automatic fill_ready_pattern();
        int   idx;
        int   run;
        logic level;
        idx = 0;
        while (idx < PATTERN_LEN) begin
            if ($urandom_range(2, 0) == 0) begin
                level = 1'b0;
                run   = $urandom_range(40, 12);
            end else begin
                level = 1'b1;
                run   = $urandom_range(5, 1);
            end
            while (run > 0 && idx < PATTERN_LEN) begin
                ready_pattern[idx] = level;
                idx = idx + 1;
                run = run - 1;
            end
        end
    endtask

    // starts on a rising edge and returns on the edge that takes the byte
    task automatic send_byte(input data_byte_t value, input logic last);
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        data_in  <= value;
        last_in  <= last;
        valid_in <= 1'b1;
        while (!accepted && waited < WAIT_LIMIT) begin
            @(negedge clk);
            accepted = ready_out;  // stable mid-cycle
            @(posedge clk);
            waited = waited + 1;
        end
        if (!accepted) begin
            $display("timeout: byte %h was not accepted within %0d cycles",
                     value, WAIT_LIMIT);
            tb_errors = tb_errors + 1;
            timed_out = 1'b1;
        end
    endtask

    task automatic apply_table(input logic with_gaps);
        int f;
        int b;
        int byte_idx;
        int gap;
        byte_idx = 0;
        for (f = 0; f < N_FRAMES && !timed_out; f++) begin
            for (b = 0; b < FRAME_LEN[f] && !timed_out; b++) begin
                send_byte(TABLE_BYTES[byte_idx], b == FRAME_LEN[f] - 1);
                byte_idx = byte_idx + 1;
                gap = with_gaps ? $urandom_range(3, 0) : 0;
                if (gap > 0) begin
                    valid_in <= 1'b0;
                    repeat (gap) @(posedge clk);
                end
            end
        end
        valid_in <= 1'b0;
    endtask

    task automatic wait_for_summaries(input int total);
        int waited;
        waited = 0;
        while (frames_seen < total && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (frames_seen < total) begin
            $display("timeout: only %0d of %0d summaries came out", frames_seen, total);
            tb_errors = tb_errors + 1;
            timed_out = 1'b1;
        end
    endtask

    // summary_ready source
    initial begin
        int cycle;
        cycle         = 0;
        summary_ready = 1'b1;
        forever begin
            @(posedge clk);
            if (phase == 1) begin
                summary_ready <= ready_pattern[cycle % PATTERN_LEN];
                cycle = cycle + 1;
            end else begin
                summary_ready <= 1'b1;
            end
        end
    end

    initial begin
        int stalls_before;
        void'($urandom(SEED));
        rst_n     = 1'b0;
        data_in   = '0;
        last_in   = 1'b0;
        valid_in  = 1'b0;
        phase     = 0;
        tb_errors = 0;
        timed_out = 1'b0;
        fill_ready_pattern();

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);  // checker looks at the idle outputs here

        apply_table(1'b0);  // one byte per cycle without back-pressure
        if (!timed_out) begin
            wait_for_summaries(N_FRAMES);
        end

        stalls_before = stall_cycles;
        if (!timed_out) begin
            @(posedge clk);
            phase <= 1;
            apply_table(1'b1);
        end
        if (!timed_out) begin
            wait_for_summaries(N_PASSES * N_FRAMES);
        end
        if (!timed_out) begin
            if (stall_cycles == stalls_before) begin
                $display("back-pressure: ready_out never dropped while summaries were held");
                tb_errors = tb_errors + 1;
            end else begin
                $display("back-pressure: ready_out held a byte off for %0d cycles, ok",
                         stall_cycles - stalls_before);
            end
        end

        $display("checks passed %0d, failed %0d, other errors %0d",
                 pass_count, fail_count, tb_errors);
        if (tb_errors == 0 && fail_count == 0 && frames_seen == N_PASSES * N_FRAMES) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
hw/frame_parity_pkg.sv
hw/byte_parity_stage.sv
hw/parity_beat_fifo.sv
hw/frame_parity_packer.sv
hw/frame_parity_unit.sv
test/frame_parity_checker.sv
test/frame_parity_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the frame parity testbench with Verilator, then look for the pass line in the log

set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
SIM_BIN=frame_parity_sim
LOG_FILE=sim.log

rm -rf "$BUILD_DIR"
rm -f "$LOG_FILE"

verilator --binary --timing -Wno-fatal \
    --top-module frame_parity_tb \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN" \
    -f files.f

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1 || true
cat "$LOG_FILE"

if grep -qx "TESTBENCH PASSED" "$LOG_FILE"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG_FILE"
    exit 1
fi
